/* rtl/chunk_cmd_settings.svh */
/*
 * Size settings for the chunk command slave.
 * Include in any file that needs link, word or register bank widths.
 */
`ifndef CHUNK_CMD_SETTINGS_SVH
`define CHUNK_CMD_SETTINGS_SVH

// Link chunk width
`define CHUNK_CMD_LINK_W 4
// Command and response word width
`define CHUNK_CMD_WORD_W 16
// Chunks per word, most significant first on the link
`define CHUNK_CMD_CHUNKS 4
// Register bank
`define CHUNK_CMD_REG_COUNT 16
`define CHUNK_CMD_DATA_W 8

`endif

/* rtl/chunk_cmd_pkg.sv */
/*
 * Types shared by the chunk command slave and its testbench.
 * Refer to them as chunk_cmd_pkg::name.
 */
`include "chunk_cmd_settings.svh"

package chunk_cmd_pkg;

	// Width of opcode, address, tag and status fields
	localparam int FIELD_W = (`CHUNK_CMD_WORD_W - `CHUNK_CMD_DATA_W) / 2;

	typedef enum logic [FIELD_W-1:0] {
		NOP   = 0,
		WRITE = 1,
		READ  = 2,
		ADD   = 3,
		XOR   = 4
	} opcode_t;

	typedef enum logic [FIELD_W-1:0] {
		OK         = 0,
		BAD_OPCODE = 1
	} status_t;

	// Opcode kept raw here, legality is judged by the decoder
	typedef struct packed {
		logic [FIELD_W-1:0]           op;
		logic [FIELD_W-1:0]           addr;
		logic [`CHUNK_CMD_DATA_W-1:0] operand;
	} cmd_word_t;

	typedef struct packed {
		logic [FIELD_W-1:0]           tag;
		status_t                      status;
		logic [`CHUNK_CMD_DATA_W-1:0] data;
	} rsp_word_t;

endpackage

/* rtl/chunk_shifter.sv */
/*
 * Word-wide shift register moving one link chunk per step.
 * Load takes a whole word, shift moves left and enters a chunk at the bottom.
 * Serves both the command and the response word through word_t.
 */
`timescale 1ns/1ps
`include "chunk_cmd_settings.svh"

module chunk_shifter #(
	parameter type word_t = logic [`CHUNK_CMD_WORD_W-1:0]
) (
	input  logic                         rvx_port_7,
	input  logic                         rvx_port_1,
	input  logic                         load,
	input  word_t                        load_word,
	input  logic                         shift,
	input  logic [`CHUNK_CMD_LINK_W-1:0] shift_chunk,
	output word_t                        word,
	output logic [`CHUNK_CMD_LINK_W-1:0] top_chunk
);

	localparam int WORD_BITS = $bits(word_t);

	always_ff @(posedge rvx_port_7 or negedge rvx_port_1)
	begin
		if (!rvx_port_1)
		begin
			word <= '0;
		end
		else if (load)
		begin
			word <= load_word;
		end
		else if (shift)
		begin
			// Oldest chunk leaves at the top
			word <= word_t'({word[WORD_BITS-`CHUNK_CMD_LINK_W-1:0], shift_chunk});
		end
	end

	assign top_chunk = word[WORD_BITS-1 -: `CHUNK_CMD_LINK_W];

endmodule

/* rtl/chunk_exchange.sv */
/*
 * Link-side controller of the command slave.
 * Gathers four inbound chunks into a command word, offers it inward,
 * waits for the response word and sends it back chunk by chunk.
 * Only one command is handled at a time.
 */
`timescale 1ns/1ps
`include "chunk_cmd_settings.svh"

module chunk_exchange (
	input  logic                         rvx_port_7,
	input  logic                         rvx_port_1,
	input  logic [`CHUNK_CMD_LINK_W-1:0] in_chunk,
	input  logic                         in_valid,
	output logic                         in_ready,
	output logic [`CHUNK_CMD_LINK_W-1:0] out_chunk,
	output logic                         out_valid,
	input  logic                         out_ready,
	output chunk_cmd_pkg::cmd_word_t     cmd_word,
	output logic                         cmd_valid,
	input  logic                         cmd_ready,
	input  chunk_cmd_pkg::rsp_word_t     rsp_word,
	input  logic                         rsp_valid,
	output logic                         rsp_ready
);

	localparam int COUNT_W = $clog2(`CHUNK_CMD_CHUNKS);

	typedef enum logic [2:0] {
		IDLE,
		RECEIVE,
		OFFER,
		AWAIT,
		SEND
	} state_t;

	state_t state;
	logic [COUNT_W-1:0] count;

	logic in_fire;
	logic out_fire;
	logic rsp_fire;
	logic last_count;
	logic in_last;
	logic out_last;

	// ******************************
	// Handshakes and chunk counting
	// ******************************

	assign in_ready  = (state == IDLE) || (state == RECEIVE);
	assign cmd_valid = (state == OFFER);
	assign rsp_ready = (state == AWAIT);
	assign out_valid = (state == SEND);

	assign in_fire  = in_valid && in_ready;
	assign out_fire = out_valid && out_ready;
	assign rsp_fire = rsp_valid && rsp_ready;

	assign last_count = (count == COUNT_W'(`CHUNK_CMD_CHUNKS - 1));
	assign in_last    = in_fire && last_count;
	assign out_last   = out_fire && last_count;

	// Shared by both directions, they never overlap
	always_ff @(posedge rvx_port_7 or negedge rvx_port_1)
	begin
		if (!rvx_port_1)
		begin
			count <= '0;
		end
		else if (in_last || out_last)
		begin
			count <= '0;
		end
		else if (in_fire || out_fire)
		begin
			count <= count + 1'b1;
		end
	end

	// ******************************
	// State machine
	// ******************************

	always_ff @(posedge rvx_port_7 or negedge rvx_port_1)
	begin
		if (!rvx_port_1)
		begin
			state <= IDLE;
		end
		else
		begin
			case (state)
				IDLE, RECEIVE:
				begin
					if (in_last)
						state <= OFFER;
					else if (in_fire)
						state <= RECEIVE;
				end
				OFFER:
				begin
					if (cmd_ready)
						state <= AWAIT;
				end
				AWAIT:
				begin
					if (rsp_fire)
						state <= SEND;
				end
				SEND:
				begin
					if (out_last)
						state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// ******************************
	// Word shifters
	// ******************************

	// Command chunks enter at the bottom, first chunk ends on top
	chunk_shifter #(
		.word_t(chunk_cmd_pkg::cmd_word_t)
	) cmd_shifter_inst (
		.rvx_port_7 (rvx_port_7),
		.rvx_port_1 (rvx_port_1),
		.load       (1'b0),
		.load_word  ('0),
		.shift      (in_fire),
		.shift_chunk(in_chunk),
		.word       (cmd_word),
		.top_chunk  ()
	);

	// Bottom filler never reaches the link
	chunk_shifter #(
		.word_t(chunk_cmd_pkg::rsp_word_t)
	) rsp_shifter_inst (
		.rvx_port_7 (rvx_port_7),
		.rvx_port_1 (rvx_port_1),
		.load       (rsp_fire),
		.load_word  (rsp_word),
		.shift      (out_fire),
		.shift_chunk('0),
		.word       (),
		.top_chunk  (out_chunk)
	);

endmodule

/* rtl/cmd_decode.sv */
/*
 * Decode stage of the command pipeline.
 * Splits the command word into opcode, address and operand, one register
 * stage deep, and marks opcodes outside the known set as bad.
 */
`timescale 1ns/1ps
`include "chunk_cmd_settings.svh"

module cmd_decode (
	input  logic                                     rvx_port_7,
	input  logic                                     rvx_port_1,
	input  chunk_cmd_pkg::cmd_word_t                 cmd_word,
	input  logic                                     cmd_valid,
	output logic                                     cmd_ready,
	output chunk_cmd_pkg::opcode_t                   dec_op,
	output logic [chunk_cmd_pkg::FIELD_W-1:0]        dec_addr,
	output logic [`CHUNK_CMD_DATA_W-1:0]             dec_operand,
	output logic                                     dec_bad,
	output logic                                     dec_valid,
	input  logic                                     dec_ready
);

	logic op_bad;

	assign cmd_ready = !dec_valid || dec_ready;

	always_comb
	begin
		case (cmd_word.op)
			chunk_cmd_pkg::NOP,
			chunk_cmd_pkg::WRITE,
			chunk_cmd_pkg::READ,
			chunk_cmd_pkg::ADD,
			chunk_cmd_pkg::XOR:
				op_bad = 1'b0;
			default:
				op_bad = 1'b1;
		endcase
	end

	always_ff @(posedge rvx_port_7 or negedge rvx_port_1)
	begin
		if (!rvx_port_1)
			dec_valid <= 1'b0;
		else if (cmd_ready)
			dec_valid <= cmd_valid;
	end

	// Fields
	always_ff @(posedge rvx_port_7)
	begin
		if (cmd_valid && cmd_ready)
		begin
			dec_op      <= chunk_cmd_pkg::opcode_t'(cmd_word.op);
			dec_addr    <= cmd_word.addr;
			dec_operand <= cmd_word.operand;
			dec_bad     <= op_bad;
		end
	end

endmodule

/* rtl/reg_execute.sv */
/*
 * Execute stage holding the sixteen-entry register bank.
 * Performs write, read, add and xor on decoded commands and registers
 * the status and result data for the response stage.
 */
`timescale 1ns/1ps
`include "chunk_cmd_settings.svh"

module reg_execute (
	input  logic                                     rvx_port_7,
	input  logic                                     rvx_port_1,
	input  chunk_cmd_pkg::opcode_t                   dec_op,
	input  logic [chunk_cmd_pkg::FIELD_W-1:0]        dec_addr,
	input  logic [`CHUNK_CMD_DATA_W-1:0]             dec_operand,
	input  logic                                     dec_bad,
	input  logic                                     dec_valid,
	output logic                                     dec_ready,
	output chunk_cmd_pkg::status_t                   exe_status,
	output logic [`CHUNK_CMD_DATA_W-1:0]             exe_data,
	output logic                                     exe_valid,
	input  logic                                     exe_ready
);

	logic [`CHUNK_CMD_DATA_W-1:0] bank [`CHUNK_CMD_REG_COUNT];

	logic                         dec_fire;
	logic [`CHUNK_CMD_DATA_W-1:0] cur_value;
	logic [`CHUNK_CMD_DATA_W-1:0] new_value;
	logic                         bank_we;
	chunk_cmd_pkg::status_t       new_status;

	assign dec_ready = !exe_valid || exe_ready;
	assign dec_fire  = dec_valid && dec_ready;
	assign cur_value = bank[dec_addr];

	// ******************************
	// Command effect
	// ******************************

	always_comb
	begin
		new_value  = '0;
		bank_we    = 1'b0;
		new_status = chunk_cmd_pkg::OK;
		if (dec_bad)
		begin
			new_status = chunk_cmd_pkg::BAD_OPCODE;
		end
		else
		begin
			case (dec_op)
				chunk_cmd_pkg::WRITE:
				begin
					new_value = dec_operand;
					bank_we   = 1'b1;
				end
				chunk_cmd_pkg::READ:
				begin
					new_value = cur_value;
				end
				chunk_cmd_pkg::ADD:
				begin
					// Wraps at the data width
					new_value = cur_value + dec_operand;
					bank_we   = 1'b1;
				end
				chunk_cmd_pkg::XOR:
				begin
					new_value = cur_value ^ dec_operand;
					bank_we   = 1'b1;
				end
				default:
				begin
					new_value = '0;
				end
			endcase
		end
	end

	always_ff @(posedge rvx_port_7 or negedge rvx_port_1)
	begin
		if (!rvx_port_1)
		begin
			for (int i = 0; i < `CHUNK_CMD_REG_COUNT; i++)
				bank[i] <= '0;
			exe_valid <= 1'b0;
		end
		else
		begin
			if (dec_fire && bank_we)
				bank[dec_addr] <= new_value;
			if (dec_ready)
				exe_valid <= dec_valid;
		end
	end

	always_ff @(posedge rvx_port_7)
	begin
		if (dec_fire)
		begin
			exe_status <= new_status;
			exe_data   <= new_value;
		end
	end

endmodule

/* rtl/rsp_format.sv */
/*
 * Result stage that packs status and data into a response word.
 * Each response carries a 4-bit sequence tag, advanced per sent response.
 */
`timescale 1ns/1ps
`include "chunk_cmd_settings.svh"

module rsp_format (
	input  logic                         rvx_port_7,
	input  logic                         rvx_port_1,
	input  chunk_cmd_pkg::status_t       exe_status,
	input  logic [`CHUNK_CMD_DATA_W-1:0] exe_data,
	input  logic                         exe_valid,
	output logic                         exe_ready,
	output chunk_cmd_pkg::rsp_word_t     rsp_word,
	output logic                         rsp_valid,
	input  logic                         rsp_ready
);

	logic [chunk_cmd_pkg::FIELD_W-1:0] tag;
	logic [chunk_cmd_pkg::FIELD_W-1:0] load_tag;
	logic                              rsp_fire;

	assign exe_ready = !rsp_valid || rsp_ready;
	assign rsp_fire  = rsp_valid && rsp_ready;
	// Tag as it stands once the pending response has left
	assign load_tag  = rsp_fire ? tag + 1'b1 : tag;

	always_ff @(posedge rvx_port_7 or negedge rvx_port_1)
	begin
		if (!rvx_port_1)
		begin
			tag       <= '0;
			rsp_valid <= 1'b0;
		end
		else
		begin
			if (rsp_fire)
				tag <= tag + 1'b1;
			if (exe_ready)
				rsp_valid <= exe_valid;
		end
	end

	always_ff @(posedge rvx_port_7)
	begin
		if (exe_valid && exe_ready)
			rsp_word <= {load_tag, exe_status, exe_data};
	end

endmodule

/* rtl/chunk_cmd_top.sv */
/*
 * Top level of the chunk command slave.
 * Link exchanger followed by decode, execute and result stages.
 */
`timescale 1ns/1ps
`include "chunk_cmd_settings.svh"

module chunk_cmd_top (
	input  logic                         rvx_port_7,
	input  logic                         rvx_port_1,
	input  logic [`CHUNK_CMD_LINK_W-1:0] in_chunk,
	input  logic                         in_valid,
	output logic                         in_ready,
	output logic [`CHUNK_CMD_LINK_W-1:0] out_chunk,
	output logic                         out_valid,
	input  logic                         out_ready
);

	chunk_cmd_pkg::cmd_word_t          cmd_word;
	logic                              cmd_valid;
	logic                              cmd_ready;
	chunk_cmd_pkg::opcode_t            dec_op;
	logic [chunk_cmd_pkg::FIELD_W-1:0] dec_addr;
	logic [`CHUNK_CMD_DATA_W-1:0]      dec_operand;
	logic                              dec_bad;
	logic                              dec_valid;
	logic                              dec_ready;
	chunk_cmd_pkg::status_t            exe_status;
	logic [`CHUNK_CMD_DATA_W-1:0]      exe_data;
	logic                              exe_valid;
	logic                              exe_ready;
	chunk_cmd_pkg::rsp_word_t          rsp_word;
	logic                              rsp_valid;
	logic                              rsp_ready;

	chunk_exchange chunk_exchange_inst (
		.rvx_port_7(rvx_port_7),
		.rvx_port_1(rvx_port_1),
		.in_chunk  (in_chunk),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_chunk (out_chunk),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.cmd_word  (cmd_word),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.rsp_word  (rsp_word),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready)
	);

	// ******************************
	// Inner pipeline
	// ******************************

	cmd_decode cmd_decode_inst (
		.rvx_port_7 (rvx_port_7),
		.rvx_port_1 (rvx_port_1),
		.cmd_word   (cmd_word),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.dec_op     (dec_op),
		.dec_addr   (dec_addr),
		.dec_operand(dec_operand),
		.dec_bad    (dec_bad),
		.dec_valid  (dec_valid),
		.dec_ready  (dec_ready)
	);

	reg_execute reg_execute_inst (
		.rvx_port_7 (rvx_port_7),
		.rvx_port_1 (rvx_port_1),
		.dec_op     (dec_op),
		.dec_addr   (dec_addr),
		.dec_operand(dec_operand),
		.dec_bad    (dec_bad),
		.dec_valid  (dec_valid),
		.dec_ready  (dec_ready),
		.exe_status (exe_status),
		.exe_data   (exe_data),
		.exe_valid  (exe_valid),
		.exe_ready  (exe_ready)
	);

	rsp_format rsp_format_inst (
		.rvx_port_7(rvx_port_7),
		.rvx_port_1(rvx_port_1),
		.exe_status(exe_status),
		.exe_data  (exe_data),
		.exe_valid (exe_valid),
		.exe_ready (exe_ready),
		.rsp_word  (rsp_word),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready)
	);

endmodule

/* verification/chunk_cmd_tb.sv */
/*
 * Directed testbench for the chunk command slave.
 * Sends command words over the inbound chunk link, collects the response
 * chunks and compares each response word with a register bank model.
 */
`timescale 1ns/1ps
`include "chunk_cmd_settings.svh"

module chunk_cmd_tb;

	localparam int LINK_W = `CHUNK_CMD_LINK_W;
	localparam int WORD_W = `CHUNK_CMD_WORD_W;
	// About 60 commands, each well under 30 cycles even with stalls
	localparam int MAX_CYCLES = 2000;

	logic              rvx_port_7 = 1'b0;
	logic              rvx_port_1;
	logic [LINK_W-1:0] in_chunk;
	logic              in_valid;
	logic              in_ready;
	logic [LINK_W-1:0] out_chunk;
	logic              out_valid;
	logic              out_ready;

	logic [`CHUNK_CMD_DATA_W-1:0] model_regs [`CHUNK_CMD_REG_COUNT];
	logic [3:0]                   model_tag;
	int                           error_count;
	int                           check_count;
	int                           cycle_count;

	chunk_cmd_top chunk_cmd_top_inst (
		.rvx_port_7(rvx_port_7),
		.rvx_port_1(rvx_port_1),
		.in_chunk  (in_chunk),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_chunk (out_chunk),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	always #2 rvx_port_7 = ~rvx_port_7;

	// ******************************
	// Checking and reference model
	// ******************************

	task automatic check_value(input string name, input logic [WORD_W-1:0] expected,
		input logic [WORD_W-1:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
			error_count++;
		end
	endtask

	// Predicts the response word and updates the model bank
	task automatic model_apply(input logic [3:0] op, input logic [3:0] addr,
		input logic [7:0] operand, output logic [WORD_W-1:0] expected);
		logic [7:0] data;
		logic [3:0] status;
		data   = 8'h00;
		status = chunk_cmd_pkg::OK;
		case (op)
			chunk_cmd_pkg::NOP:   data = 8'h00;
			chunk_cmd_pkg::WRITE:
			begin
				model_regs[addr] = operand;
				data = operand;
			end
			chunk_cmd_pkg::READ:  data = model_regs[addr];
			chunk_cmd_pkg::ADD:
			begin
				model_regs[addr] = model_regs[addr] + operand;
				data = model_regs[addr];
			end
			chunk_cmd_pkg::XOR:
			begin
				model_regs[addr] = model_regs[addr] ^ operand;
				data = model_regs[addr];
			end
			default: status = chunk_cmd_pkg::BAD_OPCODE;
		endcase
		expected  = {model_tag, status, data};
		model_tag = model_tag + 1'b1;
	endtask

	// ******************************
	// Link driver and monitor
	// ******************************

	// Called 1 ns after a rising edge, returns at the same point
	task automatic send_cmd(input logic [WORD_W-1:0] word);
		for (int i = 0; i < 4; i++)
		begin
			in_chunk = word[WORD_W-1-LINK_W*i -: LINK_W];
			in_valid = 1'b1;
			while (!in_ready)
			begin
				@(posedge rvx_port_7);
				#1;
			end
			@(posedge rvx_port_7);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic recv_rsp(input bit stall, output logic [WORD_W-1:0] word);
		int got;
		got  = 0;
		word = '0;
		while (got < 4)
		begin
			out_ready = stall ? 1'($urandom % 2) : 1'b1;
			// No new command may enter while a response is pending
			check_value("in_ready", 0, in_ready);
			if (out_valid && out_ready)
			begin
				word = {word[WORD_W-LINK_W-1:0], out_chunk};
				got++;
			end
			@(posedge rvx_port_7);
			#1;
		end
		out_ready = 1'b0;
	endtask

	task automatic run_cmd(input logic [3:0] op, input logic [3:0] addr,
		input logic [7:0] operand, input bit stall);
		logic [WORD_W-1:0] expected;
		logic [WORD_W-1:0] actual;
		model_apply(op, addr, operand, expected);
		send_cmd({op, addr, operand});
		recv_rsp(stall, actual);
		check_value("rsp_word", expected, actual);
	endtask

	// ******************************
	// Directed tests
	// ******************************

	task automatic test_reset_reads();
		check_value("in_ready", 1, in_ready);
		check_value("out_valid", 0, out_valid);
		for (int a = 0; a < `CHUNK_CMD_REG_COUNT; a++)
			run_cmd(chunk_cmd_pkg::READ, 4'(a), 8'h00, 1'b0);
	endtask

	task automatic test_write_read();
		run_cmd(chunk_cmd_pkg::WRITE, 4'h0, 8'h5a, 1'b0);
		run_cmd(chunk_cmd_pkg::WRITE, 4'h3, 8'hc3, 1'b0);
		run_cmd(chunk_cmd_pkg::WRITE, 4'h9, 8'h01, 1'b0);
		run_cmd(chunk_cmd_pkg::WRITE, 4'hf, 8'hff, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'h0, 8'h00, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'h3, 8'h00, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'h9, 8'h00, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'hf, 8'h00, 1'b0);
		// Neighbours of written registers
		run_cmd(chunk_cmd_pkg::READ, 4'h4, 8'h00, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'he, 8'h00, 1'b0);
	endtask

	task automatic test_add_xor();
		run_cmd(chunk_cmd_pkg::WRITE, 4'h6, 8'hf0, 1'b0);
		run_cmd(chunk_cmd_pkg::ADD, 4'h6, 8'h25, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'h6, 8'h00, 1'b0);
		run_cmd(chunk_cmd_pkg::WRITE, 4'h7, 8'h3c, 1'b0);
		run_cmd(chunk_cmd_pkg::XOR, 4'h7, 8'hff, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'h7, 8'h00, 1'b0);
	endtask

	task automatic test_bad_nop();
		run_cmd(4'hb, 4'h3, 8'h77, 1'b0);
		run_cmd(chunk_cmd_pkg::NOP, 4'h3, 8'h77, 1'b0);
		run_cmd(chunk_cmd_pkg::READ, 4'h3, 8'h00, 1'b0);
	endtask

	task automatic test_stalled_rsp();
		run_cmd(chunk_cmd_pkg::WRITE, 4'h2, 8'ha5, 1'b1);
		run_cmd(chunk_cmd_pkg::READ, 4'h2, 8'h00, 1'b1);
		run_cmd(chunk_cmd_pkg::ADD, 4'h2, 8'h11, 1'b1);
		// Link reopens once the last chunk has left
		check_value("in_ready", 1, in_ready);
	endtask

	task automatic test_random_cmds();
		int unsigned sel;
		logic [3:0]  op;
		for (int n = 0; n < 20; n++)
		begin
			sel = $urandom % 6;
			case (sel)
				0: op = chunk_cmd_pkg::NOP;
				1: op = chunk_cmd_pkg::WRITE;
				2: op = chunk_cmd_pkg::READ;
				3: op = chunk_cmd_pkg::ADD;
				4: op = chunk_cmd_pkg::XOR;
				default: op = 4'(5 + $urandom % 11);
			endcase
			run_cmd(op, 4'($urandom % 16), 8'($urandom % 256), 1'($urandom % 2));
		end
	endtask

	// ******************************
	// Run control
	// ******************************

	initial
	begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES)
		begin
			@(posedge rvx_port_7);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles without finishing the tests", cycle_count);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		rvx_port_1  = 1'b0;
		in_chunk    = '0;
		in_valid    = 1'b0;
		out_ready   = 1'b0;
		error_count = 0;
		check_count = 0;
		model_tag   = 4'h0;
		void'($urandom(32'h452bc2bc));
		for (int r = 0; r < `CHUNK_CMD_REG_COUNT; r++)
			model_regs[r] = 8'h00;
		repeat (8) @(posedge rvx_port_7);
		#1;
		rvx_port_1 = 1'b1;

		test_reset_reads();
		test_write_read();
		test_add_xor();
		test_bad_nop();
		test_stalled_rsp();
		test_random_cmds();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* chunk_cmd.f */
+incdir+rtl
rtl/chunk_cmd_pkg.sv
rtl/chunk_shifter.sv
rtl/chunk_exchange.sv
rtl/cmd_decode.sv
rtl/reg_execute.sv
rtl/rsp_format.sv
rtl/chunk_cmd_top.sv
verification/chunk_cmd_tb.sv
